//--- test/fetch_cases.txt
# C boot_addr(hex) branch_taken | W count words(hex) | R count retire_pcs(hex)
# S stall_at_retire_count stall_cycles (decimal, 0 0 for no burst) closes each case
# Sequential code, boot block wraps to word 0, stall burst after three retirements
C 00000113 0
W 6 00108093 00208093 00308093 00408093 00508093 00608093
R 6 00000100 00000104 00000108 0000010c 00000110 00000114
S 3 4
# JAL forward, then a backward JAL closing a loop
C 00000040 0
W 5 00108093 0080006f 00208093 00308093 ff5ff06f
R 7 00000040 00000044 0000004c 00000050 00000044 0000004c 00000050
S 0 0
# Taken branch
C 00000080 1
W 6 00108093 00000663 00208093 00308093 00408093 00508093
R 4 00000080 00000084 00000090 00000094
S 0 0
# Same branch not taken
C 00000080 0
W 6 00108093 00000663 00208093 00308093 00408093 00508093
R 6 00000080 00000084 00000088 0000008c 00000090 00000094
S 0 0
# Illegal word at D0, handler MRET at boot block plus 8
C 000000c4 0
W 7 00108093 00c0006f 30200073 00208093 00000000 00308093 00408093
R 5 000000c0 000000c4 000000c8 000000d4 000000d8
S 0 0
# Stall burst while a JAL sits in EX
C 00000020 0
W 8 00108093 00208093 00308093 0080006f 00408093 00508093 00608093 00708093
R 7 00000020 00000024 00000028 0000002c 00000034 00000038 0000003c
S 4 3

//--- compile.f
hdl/fetch_pkg.sv
hdl/if_stage.sv
hdl/instr_mem.sv
hdl/id_control.sv
hdl/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/if_stage.sv
  - hdl/instr_mem.sv
  - hdl/id_control.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - test/fetch_checker.sv
      - test/fetch_tb.sv

//--- test/fetch_tb.sv
// Fetch front end testbench
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam int CLK_PERIOD     = 40;   // ns
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = 100;  // Per case, counted after the boot pulse
  localparam int MAX_WORDS      = 16;   // Longest program or retire list
  localparam int DRAIN_CYCLES   = 2;    // Shadow and bubble, or illegal and its squash

  // Illegal opcode 0 placed after each program
  localparam logic [XLEN-1:0] GUARD_WORD = '0;

  // DUT ports
  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] boot_addr;
  logic            start;
  logic            stall;
  logic            branch_taken;
  logic            imem_we;
  logic [XLEN-1:0] imem_waddr;
  logic [XLEN-1:0] imem_wdata;
  logic            retire_valid;
  logic [XLEN-1:0] retire_pc;
  logic [XLEN-1:0] retire_instr;

  // Case under test
  logic [XLEN-1:0] prog [MAX_WORDS];    // Program image from the boot block up
  logic [XLEN-1:0] exp_pc [MAX_WORDS];  // Expected retire PCs, in order
  logic [XLEN-1:0] case_boot;
  logic            case_branch;         // Level for branch_taken_i
  int              n_words;
  int              n_exp;
  int              stall_at;            // Retire count that opens the burst
  int              stall_len;           // Burst length in cycles, 0 for none
  int              case_no;

  // Case file reading
  int              fd;
  int              code;
  logic [7:0]      tag;                 // First character of a line
  logic [XLEN-1:0] value;
  logic [8*128-1:0] line;               // Rest of a comment line
  bit              done;
  bit              file_error;

  always #(CLK_PERIOD/2) clk = ~clk;

  fetch_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_addr_i    (boot_addr),
    .start_i        (start),
    .stall_i        (stall),
    .branch_taken_i (branch_taken),
    .imem_we_i      (imem_we),
    .imem_waddr_i   (imem_waddr),
    .imem_wdata_i   (imem_wdata),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_instr_o (retire_instr)
  );

  fetch_checker chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .retire_valid_i (retire_valid),
    .retire_pc_i    (retire_pc),
    .retire_instr_i (retire_instr)
  );

  // Word stored at a PC of the current program, X outside it
  function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] idx;
    base = {case_boot[XLEN-1:5], 5'b0};   // 32 byte boot block
    idx  = (pc - base) >> 2;
    if ((pc < base) || (idx >= XLEN'(n_words)))
      return 'x;
    else
      return prog[idx];
  endfunction

  // W or R line, a count and then that many hex values
  task automatic read_list(input logic [7:0] kind);
    int count;
    count = 0;
    code  = $fscanf(fd, "%d", count);
    if (count > MAX_WORDS)
      count = MAX_WORDS;
    for (int i = 0; i < count; i++)
    begin
      code = $fscanf(fd, "%h", value);
      if (kind == "W")
        prog[i] = value;
      else
        exp_pc[i] = value;
    end
    if (kind == "W")
      n_words = count;
    else
      n_exp = count;
  endtask

  ////////////////////
  // Program load
  ////////////////////
  task automatic load_program();
    logic [XLEN-1:0] base;
    base = {case_boot[XLEN-1:5], 5'b0};
    for (int i = 0; i <= n_words; i++)
    begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_waddr <= base + XLEN'(4 * i);  // One word per cycle
      imem_wdata <= (i < n_words) ? prog[i] : GUARD_WORD;
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  ////////////////////
  // One case
  ////////////////////
  task automatic run_case();
    int cycles;
    bit burst_done;
    chk.open_case();
    for (int i = 0; i < n_exp; i++)
      chk.expect_retire(exp_pc[i], word_at(exp_pc[i]));
    @(posedge clk);
    boot_addr    <= case_boot;
    branch_taken <= case_branch;
    load_program();                       // DUT still parked by stall
    @(posedge clk);
    start <= 1'b1;                        // Boot pulse releases the pipeline
    stall <= 1'b0;
    @(posedge clk);
    start <= 1'b0;
    cycles     = 0;
    burst_done = (stall_len == 0);
    while ((chk.seen_count < n_exp) && (cycles < TIMEOUT_CYCLES))
    begin
      @(posedge clk);
      cycles++;
      if (!burst_done && (chk.seen_count >= stall_at))
      begin
        stall <= 1'b1;                    // Back-pressure burst
        repeat (stall_len) @(posedge clk);
        stall      <= 1'b0;
        burst_done = 1'b1;
      end
    end
    // Window past the last expected PC where nothing may retire
    repeat (DRAIN_CYCLES) @(posedge clk);
    stall <= 1'b1;                        // Park the DUT before the next load
    chk.close_case(case_no, chk.seen_count < n_exp);
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    boot_addr    = '0;
    start        = 1'b0;
    stall        = 1'b1;
    branch_taken = 1'b0;
    imem_we      = 1'b0;
    imem_waddr   = '0;
    imem_wdata   = '0;
    case_no      = 0;
    done         = 1'b0;
    file_error   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("test/fetch_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file test/fetch_cases.txt");
      file_error = 1'b1;
      done       = 1'b1;
    end
    while (!done)
    begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1)
        done = 1'b1;                      // End of file
      else if (tag == "#")
        code = $fgets(line, fd);
      else if (tag == "C")
        code = $fscanf(fd, "%h %h", case_boot, case_branch);
      else if ((tag == "W") || (tag == "R"))
        read_list(tag);
      else if (tag == "S")
      begin
        code = $fscanf(fd, "%d %d", stall_at, stall_len);
        case_no++;
        run_case();                       // S closes a case
      end
      else
      begin
        $display("Unknown line type in the case file, reading stopped");
        file_error = 1'b1;
        done       = 1'b1;
      end
    end
    if (fd != 0)
      $fclose(fd);

    $display("Cases run %0d, passed %0d, failed %0d, errors %0d",
             case_no, chk.pass_count, chk.fail_count, chk.error_count);
    if (!file_error && (case_no > 0) && (chk.fail_count == 0) && (chk.error_count == 0))
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- test/fetch_checker.sv
// Retirement checker
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            retire_valid_i,   // DUT retire port
  input  logic [XLEN-1:0] retire_pc_i,
  input  logic [XLEN-1:0] retire_instr_i
);

  logic [XLEN-1:0] exp_pc_q [$];     // Expected PCs, oldest first
  logic [XLEN-1:0] exp_instr_q [$];  // Word stored at each of them
  logic [XLEN-1:0] want_pc;
  logic [XLEN-1:0] want_instr;

  int seen_count     = 0;  // Matched retirements of the running case
  int error_count    = 0;  // Every failure so far
  int errors_at_open = 0;
  int pass_count     = 0;
  int fail_count     = 0;

  ////////////////////
  // Case bookkeeping
  ////////////////////
  task automatic open_case();
    exp_pc_q.delete();
    exp_instr_q.delete();
    seen_count     = 0;
    errors_at_open = error_count;
  endtask

  task automatic expect_retire(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr);
    exp_pc_q.push_back(pc);
    exp_instr_q.push_back(instr);
  endtask

  // One line per case
  task automatic close_case(input int case_no, input bit timed_out);
    if (timed_out)
    begin
      error_count++;
      $display("Case %0d timed out with %0d of %0d retirements seen",
               case_no, seen_count, seen_count + exp_pc_q.size());
    end
    if (error_count == errors_at_open)
    begin
      pass_count++;
      $display("Case %0d passed, %0d retirements", case_no, seen_count);
    end
    else
    begin
      fail_count++;
      $display("Case %0d failed, %0d errors", case_no, error_count - errors_at_open);
    end
  endtask

  ////////////////////
  // Retire monitor
  ////////////////////
  // Retire ports are combinational and settle well before the falling edge
  always @(negedge clk)
  begin
    if (rst_n && retire_valid_i)
    begin
      if (exp_pc_q.size() == 0)
      begin
        error_count++;              // Nothing left to retire
        $display("Unexpected extra retirement of PC %h at time %0t", retire_pc_i, $time);
      end
      else
      begin
        want_pc    = exp_pc_q.pop_front();
        want_instr = exp_instr_q.pop_front();
        seen_count++;
        if (retire_pc_i !== want_pc)
        begin
          error_count++;
          $display("ERROR at %0t: retired PC %h, expected %h", $time, retire_pc_i, want_pc);
        end
        else if (retire_instr_i !== want_instr)
        begin
          error_count++;            // Right PC, wrong word
          $display("ERROR at %0t: PC %h retired word %h, expected %h",
                   $time, retire_pc_i, retire_instr_i, want_instr);
        end
      end
    end
  end

endmodule

//--- hdl/fetch_top.sv
// Fetch front end top level
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            start_i,
  input  logic            stall_i,
  input  logic            branch_taken_i,
  input  logic            imem_we_i,      // Program load port
  input  logic [XLEN-1:0] imem_waddr_i,
  input  logic [XLEN-1:0] imem_wdata_i,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic [XLEN-1:0] retire_instr_o
);

  // Fetch to memory
  logic [XLEN-1:0] instr_addr;
  logic [XLEN-1:0] instr_rdata;

  // Fetch to ID
  logic [XLEN-1:0] instr_rdata_id;
  logic [XLEN-1:0] current_pc_id;

  // ID back to fetch
  logic [2:0]      pc_mux_sel;
  logic            pc_mux_boot;
  logic            force_nop;
  logic [1:0]      jump_in_id;
  logic [1:0]      jump_in_ex;
  logic [XLEN-1:0] jump_target;
  logic            branch_decision;
  logic [XLEN-1:0] exception_pc_reg;
  logic            stall_id;

  if_stage u_if_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_addr_i        (boot_addr_i),
    .instr_rdata_i      (instr_rdata),
    .instr_addr_o       (instr_addr),
    .pc_mux_sel_i       (pc_mux_sel),
    .pc_mux_boot_i      (pc_mux_boot),
    .force_nop_i        (force_nop),
    .exception_pc_reg_i (exception_pc_reg),
    .jump_target_i      (jump_target),
    .jump_in_id_i       (jump_in_id),
    .jump_in_ex_i       (jump_in_ex),
    .branch_decision_i  (branch_decision),
    .stall_id_i         (stall_id),
    .current_pc_if_o    (),                 // Only used inside the stage
    .current_pc_id_o    (current_pc_id),
    .instr_rdata_id_o   (instr_rdata_id)
  );

  instr_mem u_instr_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (imem_we_i),
    .waddr_i (imem_waddr_i),
    .wdata_i (imem_wdata_i),
    .raddr_i (instr_addr),
    .rdata_o (instr_rdata)
  );

  id_control u_id_control (
    .clk                (clk),
    .rst_n              (rst_n),
    .start_i            (start_i),
    .stall_i            (stall_i),
    .branch_taken_i     (branch_taken_i),
    .instr_rdata_id_i   (instr_rdata_id),
    .current_pc_id_i    (current_pc_id),
    .pc_mux_sel_o       (pc_mux_sel),
    .pc_mux_boot_o      (pc_mux_boot),
    .force_nop_o        (force_nop),
    .jump_in_id_o       (jump_in_id),
    .jump_in_ex_o       (jump_in_ex),
    .jump_target_o      (jump_target),
    .branch_decision_o  (branch_decision),
    .exception_pc_reg_o (exception_pc_reg),
    .stall_id_o         (stall_id),
    .retire_valid_o     (retire_valid_o),
    .retire_pc_o        (retire_pc_o),
    .retire_instr_o     (retire_instr_o)
  );

endmodule

//--- hdl/id_control.sv
// Decode side fetch control
`timescale 1ns/1ps

module id_control import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,             // Boot pulse
  input  logic            stall_i,             // Back-pressure level
  input  logic            branch_taken_i,      // EX comparator result
  input  logic [XLEN-1:0] instr_rdata_id_i,
  input  logic [XLEN-1:0] current_pc_id_i,
  output logic [2:0]      pc_mux_sel_o,
  output logic            pc_mux_boot_o,
  output logic            force_nop_o,
  output logic [1:0]      jump_in_id_o,
  output logic [1:0]      jump_in_ex_o,
  output logic [XLEN-1:0] jump_target_o,
  output logic            branch_decision_o,
  output logic [XLEN-1:0] exception_pc_reg_o,
  output logic            stall_id_o,
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic [XLEN-1:0] retire_instr_o
);

  logic            booted_q;      // Set by the first start
  logic [1:0]      squash_cnt_q;  // ID slots still to drop after a redirect
  logic            bubble_q;      // ID holds the forced NOP
  logic [1:0]      jump_ex_q;     // Jump state in EX
  logic [XLEN-1:0] jump_target_q;
  logic [XLEN-1:0] epc_q;         // Exception PC

  logic [6:0]      opcode;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] target_id;
  logic [1:0]      jump_id;
  logic            ex_taken;
  logic            squash_id;
  logic            valid_id;
  logic            is_jal;
  logic            is_branch;
  logic            is_mret;
  logic            illegal_id;

  ////////////////////
  // Decode
  ////////////////////
  assign opcode = instr_rdata_id_i[6:0];

  // J-type and B-type immediates
  assign imm_j = {{12{instr_rdata_id_i[31]}}, instr_rdata_id_i[19:12],
                  instr_rdata_id_i[20], instr_rdata_id_i[30:21], 1'b0};
  assign imm_b = {{20{instr_rdata_id_i[31]}}, instr_rdata_id_i[7],
                  instr_rdata_id_i[30:25], instr_rdata_id_i[11:8], 1'b0};

  // Word after a taken jump is on the wrong path
  assign ex_taken = (jump_ex_q == JUMP_JAL) ||
                    ((jump_ex_q == JUMP_BRANCH) && branch_taken_i);

  // Dead slot: not booted, boot cycle, redirect shadow, bubble, wrong path
  assign squash_id = !booted_q || start_i || (squash_cnt_q != 2'd0) ||
                     bubble_q || ex_taken;
  assign valid_id  = !squash_id;

  assign is_jal     = valid_id && (opcode == OPCODE_JAL);
  assign is_branch  = valid_id && (opcode == OPCODE_BRANCH);
  assign is_mret    = valid_id && (opcode == OPCODE_SYSTEM) &&
                      (instr_rdata_id_i[31:7] == INSTR_MRET[31:7]);
  assign illegal_id = valid_id && !((opcode == OPCODE_OPIMM) || is_jal ||
                                    is_branch || is_mret);

  assign jump_id   = is_jal ? JUMP_JAL : (is_branch ? JUMP_BRANCH : JUMP_NONE);
  assign target_id = current_pc_id_i + (is_jal ? imm_j : imm_b);

  // PC source, stall wins
  always_comb
  begin
    if (stall_i)
      pc_mux_sel_o = PC_NO_INCR;
    else if (illegal_id)
      pc_mux_sel_o = PC_EXCEPTION;
    else if (is_mret)
      pc_mux_sel_o = PC_ERET;
    else
      pc_mux_sel_o = PC_INCR;
  end

  ////////////////////
  // Control state
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      booted_q     <= 1'b0;
      squash_cnt_q <= 2'd0;
      bubble_q     <= 1'b0;
      jump_ex_q    <= JUMP_NONE;
      epc_q        <= '0;
    end
    else if (start_i)
    begin
      booted_q     <= 1'b1;
      squash_cnt_q <= 2'd1;          // Stale fetch behind the boot vector
      bubble_q     <= 1'b0;
      jump_ex_q    <= JUMP_NONE;
    end
    else if (!stall_i)
    begin
      bubble_q  <= force_nop_o;
      jump_ex_q <= jump_id;
      if (illegal_id)
        epc_q <= current_pc_id_i + XLEN'(4);   // Resume after the bad word
      if (illegal_id || is_mret)
        squash_cnt_q <= 2'd1;
      else if (squash_cnt_q != 2'd0)
        squash_cnt_q <= squash_cnt_q - 2'd1;
    end
  end

  // Target travels with the jump state
  always_ff @(posedge clk)
  begin
    if (!stall_i)
      jump_target_q <= target_id;
  end

  ////////////////////
  // Outputs
  ////////////////////
  assign pc_mux_boot_o      = start_i;
  assign force_nop_o        = (jump_ex_q != JUMP_NONE);   // Bubble behind every jump
  assign jump_in_id_o       = jump_id;
  assign jump_in_ex_o       = stall_i ? JUMP_NONE : jump_ex_q;
  assign jump_target_o      = jump_target_q;
  assign branch_decision_o  = branch_taken_i;
  assign exception_pc_reg_o = epc_q;
  assign stall_id_o         = stall_i;

  // Retire each live ID slot as it moves on
  assign retire_valid_o = valid_id && !stall_i && !illegal_id;
  assign retire_pc_o    = current_pc_id_i;
  assign retire_instr_o = instr_rdata_id_i;

endmodule

//--- hdl/instr_mem.sv
// Instruction memory
`timescale 1ns/1ps

module instr_mem import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            we_i,       // Load strobe
  input  logic [XLEN-1:0] waddr_i,    // Byte address
  input  logic [XLEN-1:0] wdata_i,
  input  logic [XLEN-1:0] raddr_i,    // Byte address
  output logic [XLEN-1:0] rdata_o     // One cycle after raddr_i
);

  logic [XLEN-1:0]    mem [IMEM_DEPTH];
  logic [IMEM_AW-1:0] widx;           // Word index, wraps at depth
  logic [IMEM_AW-1:0] ridx;

  assign widx = waddr_i[IMEM_AW+1:2];
  assign ridx = raddr_i[IMEM_AW+1:2];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we_i)
      mem[widx] <= wdata_i;
  end

  // Registered read, every cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_o <= '0;
    else
      rdata_o <= mem[ridx];
  end

endmodule

//--- hdl/if_stage.sv
// Instruction fetch stage
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  logic [XLEN-1:0] boot_addr_i,         // Base of the boot block

  // Instruction memory side
  input  logic [XLEN-1:0] instr_rdata_i,       // Word for current_pc_if_o
  output logic [XLEN-1:0] instr_addr_o,        // Address of the next fetch

  // Control from ID
  input  logic [2:0]      pc_mux_sel_i,
  input  logic            pc_mux_boot_i,       // Load boot vector
  input  logic            force_nop_i,         // Bubble into ID
  input  logic [XLEN-1:0] exception_pc_reg_i,  // Return address for MRET
  input  logic [XLEN-1:0] jump_target_i,
  input  logic [1:0]      jump_in_id_i,
  input  logic [1:0]      jump_in_ex_i,
  input  logic            branch_decision_i,
  input  logic            stall_id_i,          // Freeze IF/ID

  // PC and IF/ID outputs
  output logic [XLEN-1:0] current_pc_if_o,
  output logic [XLEN-1:0] current_pc_id_o,
  output logic [XLEN-1:0] instr_rdata_id_o
);

  logic [XLEN-1:0] exc_pc;     // Handler address
  logic [XLEN-1:0] boot_pc;    // Boot vector
  logic [XLEN-1:0] next_pc;    // After mux and jump overrides
  logic [XLEN-1:0] pc_d;       // Value the PC register takes
  logic [XLEN-1:0] fetch_word; // Word headed for ID

  // Both vectors live in the boot block, low five bits replaced
  assign exc_pc  = {boot_addr_i[XLEN-1:5], EXC_OFF_ILLINSN};
  assign boot_pc = {boot_addr_i[XLEN-1:5], EXC_OFF_RST};

  ////////////////////
  // Next PC
  ////////////////////
  always_comb
  begin
    case (pc_mux_sel_i)
      PC_INCR:      next_pc = current_pc_if_o + XLEN'(4);
      PC_NO_INCR:   next_pc = current_pc_if_o;
      PC_EXCEPTION: next_pc = exc_pc;
      PC_ERET:      next_pc = exception_pc_reg_i;
      default:      next_pc = current_pc_if_o;
    endcase

    // Jump or branch waiting in ID, hold until it reaches EX
    if (jump_in_id_i != JUMP_NONE)
      next_pc = current_pc_if_o;

    // Redirect from EX, a not-taken branch keeps the mux result
    if (jump_in_ex_i == JUMP_JAL)
      next_pc = jump_target_i;
    else if ((jump_in_ex_i == JUMP_BRANCH) && branch_decision_i)
      next_pc = jump_target_i;
  end

  // Boot wins over everything else
  assign pc_d = pc_mux_boot_i ? boot_pc : next_pc;

  // Memory sees the PC one cycle early, so data lines up with current_pc_if_o
  assign instr_addr_o = pc_d;

  // Bubble replaces the fetched word
  assign fetch_word = force_nop_i ? NOP_INSTR : instr_rdata_i;

  ////////////////////
  // PC register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      current_pc_if_o <= '0;
    else
      current_pc_if_o <= pc_d;   // Stall holds through PC_NO_INCR
  end

  ////////////////////
  // IF/ID registers
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_rdata_id_o <= '0;
      current_pc_id_o  <= '0;
    end
    else if (!stall_id_i)
    begin
      instr_rdata_id_o <= fetch_word;
      current_pc_id_o  <= current_pc_if_o;  // Same PC as the arriving word
    end
  end

endmodule

//--- hdl/fetch_pkg.sv
// Fetch front end definitions
package fetch_pkg;

  ////////////////////
  // Widths and sizes
  ////////////////////
  localparam int XLEN       = 32;                   // Data and address width
  localparam int IMEM_DEPTH = 64;                   // Instruction words
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);   // Word address width

  ////////////////////
  // PC mux select
  ////////////////////
  localparam logic [2:0] PC_INCR      = 3'b000;     // Next sequential word
  localparam logic [2:0] PC_NO_INCR   = 3'b001;     // Hold current PC
  localparam logic [2:0] PC_EXCEPTION = 3'b100;     // Handler in boot block
  localparam logic [2:0] PC_ERET      = 3'b101;     // Back to saved PC

  // Jump state, same coding in ID and EX
  localparam logic [1:0] JUMP_NONE   = 2'b00;
  localparam logic [1:0] JUMP_JAL    = 2'b01;       // Unconditional
  localparam logic [1:0] JUMP_BRANCH = 2'b10;       // Resolved in EX

  ////////////////////
  // Boot block offsets
  ////////////////////
  // Offsets within the 32 byte aligned boot block
  localparam logic [4:0] EXC_OFF_RST     = 5'h00;   // Boot vector
  localparam logic [4:0] EXC_OFF_ILLINSN = 5'h08;   // Illegal instruction

  ////////////////////
  // Opcodes
  ////////////////////
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // Full MRET encoding
  localparam logic [31:0] INSTR_MRET = 32'h3020_0073;

  // Bubble, addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = {25'b0, OPCODE_OPIMM};

endpackage
